// ==== bit_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module bit_buffer
    import usb_fifo_pkg::*;
    import dump_format_pkg::*;
(
    input  wire                      MCLK,
    input  wire                      rst_n,

    input  wire                      wr_en_n,
    input  wire [BUF_WR_ADDR_W-1:0]  wr_addr,
    input  wire                      wr_data,

    input  wire                      rd_en,
    input  wire [BUF_RD_ADDR_W-1:0]  rd_addr,
    output fifo_byte_t               rd_data
);

    fifo_byte_t mem [0:BUF_BITS/8-1];

    // bit a goes to byte a/8, lsb first
    always_ff @(posedge MCLK) begin
        if (!wr_en_n) begin
            mem[wr_addr[BUF_WR_ADDR_W-1:3]][wr_addr[2:0]] <= wr_data;
        end
    end

    always_ff @(posedge MCLK or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];   // valid the cycle after the strobe
        end
    end

endmodule

`default_nettype wire

// ==== dump_format_pkg.sv ====
`default_nettype none

package dump_format_pkg;

    // dump buffer geometry
    localparam int BUF_BITS      = 8192;   // 8 Kbit, filled one bit at a time
    localparam int BUF_WR_ADDR_W = 13;     // bit address
    localparam int BUF_RD_ADDR_W = 10;     // byte address

    // text ROM layout
    localparam int ROM_ADDR_W = 7;         // 128 entries
    localparam logic [ROM_ADDR_W-1:0] ROM_HEX_BASE   = 7'h00;   // '0'..'9', 'A'..'F'
    localparam logic [ROM_ADDR_W-1:0] ROM_BOOT_TITLE = 7'h10;
    localparam logic [ROM_ADDR_W-1:0] ROM_USER_TITLE = 7'h50;

    // title strings, first character in the top byte
    localparam int BOOT_TITLE_LEN = 17;
    localparam logic [8*BOOT_TITLE_LEN-1:0] BOOT_TITLE = "BOOT LOADER BLOCK";
    localparam int USER_TITLE_LEN = 10;
    localparam logic [8*USER_TITLE_LEN-1:0] USER_TITLE = "USER PAGE ";

    // line format
    localparam int BYTES_PER_LINE = 16;    // "HH " groups per line
    localparam int BOOT_LINES     = 30;
    localparam int USER_LINES     = 8;

    // relative page number printed after the user title
    localparam int PAGE_W      = 12;
    localparam int PAGE_DIGITS = 3;        // one hex digit per nibble

endpackage

`default_nettype wire

// ==== dump_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module dump_sequencer
    import usb_fifo_pkg::*;
    import dump_format_pkg::*;
(
    input  wire                       MCLK,
    input  wire                       rst_n,
    input  wire                       fifo_en_n,
    input  wire                       send_boot_n,
    input  wire                       send_user_n,
    input  wire  [PAGE_W-1:0]         rel_page,

    output logic                      buf_rd_en,
    output logic [BUF_RD_ADDR_W-1:0]  buf_rd_addr,
    input  wire  [7:0]                buf_rd_data,

    output logic                      rom_rd_en,
    output logic [ROM_ADDR_W-1:0]     rom_addr,
    input  wire  [7:0]                rom_data,

    output logic                      char_send,
    output fifo_byte_t                char_byte,
    input  wire                       char_done
);

    typedef enum logic [3:0] {
        S_READY,
        S_TITLE,
        S_PAGE,
        S_PAGE_CR,
        S_PAGE_LF,
        S_BUF_RD,
        S_HI,
        S_LO,
        S_SPACE,
        S_LINE_CR,
        S_LINE_LF,
        S_END_CR,
        S_END_LF,
        S_RELEASE
    } seq_state_t;

    // sub-steps of every character state
    typedef enum logic [1:0] {
        P_LOOKUP,   // ROM or buffer address settles
        P_SEND,
        P_WAIT      // writer busy until char_done
    } phase_t;

    seq_state_t         state;
    seq_state_t         after;
    phase_t             phase;
    logic               is_boot;
    logic [PAGE_W-1:0]  page_q;      // shifted left one digit per character
    logic [4:0]         char_idx;
    logic [1:0]         digit_idx;
    logic [3:0]         byte_cnt;
    logic [4:0]         line_cnt;
    logic [4:0]         title_last;
    logic [4:0]         line_last;
    logic [3:0]         nibble;
    fifo_byte_t         emit_byte;

    // constant characters skip the lookup step
    function automatic phase_t first_phase(input seq_state_t s);
        case (s)
            S_PAGE_CR, S_PAGE_LF, S_SPACE, S_LINE_CR,
            S_LINE_LF, S_END_CR, S_END_LF: first_phase = P_SEND;
            default:                       first_phase = P_LOOKUP;
        endcase
    endfunction

    assign title_last = is_boot ? 5'(BOOT_TITLE_LEN - 1) : 5'(USER_TITLE_LEN - 1);
    assign line_last  = is_boot ? 5'(BOOT_LINES - 1) : 5'(USER_LINES - 1);

    always_comb begin
        case (state)
            S_HI:    nibble = buf_rd_data[7:4];   // high nibble first
            S_LO:    nibble = buf_rd_data[3:0];
            default: nibble = page_q[PAGE_W-1 -: 4];
        endcase
        if (state == S_TITLE) begin
            rom_addr = (is_boot ? ROM_BOOT_TITLE : ROM_USER_TITLE) + ROM_ADDR_W'(char_idx);
        end else begin
            rom_addr = ROM_HEX_BASE + ROM_ADDR_W'(nibble);
        end
    end

    always_comb begin
        case (state)
            S_PAGE_CR, S_LINE_CR, S_END_CR: emit_byte = CHAR_CR;
            S_PAGE_LF, S_LINE_LF, S_END_LF: emit_byte = CHAR_LF;
            S_SPACE:                        emit_byte = CHAR_SPACE;
            default:                        emit_byte = rom_data;
        endcase
    end

    // state that follows once the current character is written
    always_comb begin
        case (state)
            S_TITLE: begin
                if (char_idx != title_last) begin
                    after = S_TITLE;
                end else begin
                    after = is_boot ? S_BUF_RD : S_PAGE;
                end
            end
            S_PAGE:    after = (digit_idx == 2'(PAGE_DIGITS - 1)) ? S_PAGE_CR : S_PAGE;
            S_PAGE_CR: after = S_PAGE_LF;
            S_PAGE_LF: after = S_BUF_RD;
            S_HI:      after = S_LO;
            S_LO:      after = S_SPACE;
            S_SPACE:   after = (byte_cnt == 4'(BYTES_PER_LINE - 1)) ? S_LINE_CR : S_BUF_RD;
            S_LINE_CR: after = S_LINE_LF;
            S_LINE_LF: after = (line_cnt == line_last) ? S_END_CR : S_BUF_RD;
            S_END_CR:  after = S_END_LF;
            default:   after = S_RELEASE;
        endcase
    end

    always_ff @(posedge MCLK or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_READY;
            phase       <= P_LOOKUP;
            is_boot     <= 1'b0;
            page_q      <= '0;
            char_idx    <= '0;
            digit_idx   <= '0;
            byte_cnt    <= '0;
            line_cnt    <= '0;
            buf_rd_addr <= '0;
            buf_rd_en   <= 1'b0;
            rom_rd_en   <= 1'b0;
            char_send   <= 1'b0;
            char_byte   <= CHAR_SPACE;
        end else begin
            buf_rd_en <= 1'b0;
            char_send <= 1'b0;
            case (state)
                S_READY: begin
                    if (!fifo_en_n && (!send_boot_n || !send_user_n)) begin
                        is_boot     <= !send_boot_n;   // boot wins when both are low
                        page_q      <= rel_page;
                        char_idx    <= '0;
                        digit_idx   <= '0;
                        byte_cnt    <= '0;
                        line_cnt    <= '0;
                        buf_rd_addr <= '0;
                        rom_rd_en   <= 1'b1;
                        state       <= S_TITLE;
                        phase       <= P_LOOKUP;
                    end
                end
                S_RELEASE: begin
                    if (send_boot_n && send_user_n) begin
                        rom_rd_en <= 1'b0;
                        state     <= S_READY;
                    end
                end
                S_BUF_RD: begin
                    if (phase == P_LOOKUP) begin
                        buf_rd_en <= 1'b1;   // byte valid one cycle later
                        phase     <= P_SEND;
                    end else begin
                        state <= S_HI;
                        phase <= P_LOOKUP;
                    end
                end
                default: begin
                    case (phase)
                        P_LOOKUP: phase <= P_SEND;
                        P_SEND: begin
                            char_send <= 1'b1;
                            char_byte <= emit_byte;
                            phase     <= P_WAIT;
                        end
                        default: begin
                            if (char_done) begin
                                state <= after;
                                phase <= first_phase(after);
                                case (state)
                                    S_TITLE: char_idx <= char_idx + 5'd1;
                                    S_PAGE: begin
                                        digit_idx <= digit_idx + 2'd1;
                                        page_q    <= {page_q[PAGE_W-5:0], 4'h0};
                                    end
                                    S_SPACE: begin
                                        buf_rd_addr <= buf_rd_addr + 1'b1;
                                        byte_cnt    <= byte_cnt + 4'd1;   // wraps at line end
                                    end
                                    S_LINE_LF: line_cnt <= line_cnt + 5'd1;
                                    default: ;
                                endcase
                            end
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== fifo_byte_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module fifo_byte_writer
    import usb_fifo_pkg::*;
(
    input  wire         MCLK,
    input  wire         rst_n,
    input  wire         char_send,
    input  wire         [7:0] char_byte,
    input  wire         txe_n,
    output logic        char_done,
    output fifo_byte_t  fifo_data,
    output logic        fifo_wr_n
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_WAIT_ROOM,
        W_STROBE,
        W_STROBE_END
    } wr_state_t;

    wr_state_t state;
    logic      strobe_hold;   // second low cycle of the strobe

    always_ff @(posedge MCLK or negedge rst_n) begin
        if (!rst_n) begin
            state       <= W_IDLE;
            fifo_data   <= CHAR_SPACE;
            fifo_wr_n   <= 1'b1;
            char_done   <= 1'b0;
            strobe_hold <= 1'b0;
        end else begin
            char_done <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (char_send) begin
                        fifo_data <= char_byte;   // held until the write is done
                        state     <= W_WAIT_ROOM;
                    end
                end
                W_WAIT_ROOM: begin
                    if (!txe_n) begin   // FT232H has room
                        state <= W_STROBE;
                    end
                end
                W_STROBE: begin
                    fifo_wr_n   <= 1'b0;
                    strobe_hold <= 1'b0;
                    state       <= W_STROBE_END;
                end
                W_STROBE_END: begin
                    if (strobe_hold) begin
                        fifo_wr_n <= 1'b1;
                        char_done <= 1'b1;   // same cycle wr_n goes high
                        state     <= W_IDLE;
                    end else begin
                        strobe_hold <= 1'b1;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the USB dump testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation FAILED"

verilator --binary --timing --assert \
    -f src.f --top-module usb_dump_tb -Mdir obj_dir -o usb_dump_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/usb_dump_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "test failed, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "test passed"
exit 0

// ==== src.f ====
usb_fifo_pkg.sv
dump_format_pkg.sv
bit_buffer.sv
text_rom.sv
fifo_byte_writer.sv
dump_sequencer.sv
usb_dump_top.sv
tb_clock_gen.sv
usb_dump_properties.sv
usb_dump_tb.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic MCLK,
    output logic rst_n
);

    localparam int HALF_PERIOD_NS = 2;   // 4 ns clock
    localparam int RESET_CYCLES   = 2;

    initial begin
        MCLK = 1'b0;
        forever #(HALF_PERIOD_NS) MCLK = ~MCLK;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge MCLK);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== text_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module text_rom
    import usb_fifo_pkg::*;
    import dump_format_pkg::*;
(
    input  wire                   MCLK,
    input  wire                   rst_n,
    input  wire                   rd_en,
    input  wire [ROM_ADDR_W-1:0]  addr,
    output fifo_byte_t            data
);

    function automatic fifo_byte_t rom_byte(input logic [ROM_ADDR_W-1:0] a);
        int         idx;
        int         off;
        fifo_byte_t b;
        idx = int'(a);
        b   = CHAR_SPACE;   // unused entries
        if (idx >= int'(ROM_HEX_BASE) && idx < int'(ROM_HEX_BASE) + 16) begin
            off = idx - int'(ROM_HEX_BASE);
            b   = 8'(off) + ((off < 10) ? 8'h30 : 8'h37);   // '0'.. or 'A'..
        end else if (idx >= int'(ROM_BOOT_TITLE) &&
                     idx < int'(ROM_BOOT_TITLE) + BOOT_TITLE_LEN) begin
            off = idx - int'(ROM_BOOT_TITLE);
            b   = BOOT_TITLE[8*(BOOT_TITLE_LEN-1-off) +: 8];
        end else if (idx >= int'(ROM_USER_TITLE) &&
                     idx < int'(ROM_USER_TITLE) + USER_TITLE_LEN) begin
            off = idx - int'(ROM_USER_TITLE);
            b   = USER_TITLE[8*(USER_TITLE_LEN-1-off) +: 8];
        end
        return b;
    endfunction

    always_ff @(posedge MCLK or negedge rst_n) begin
        if (!rst_n) begin
            data <= CHAR_SPACE;
        end else if (rd_en) begin
            data <= rom_byte(addr);   // one cycle latency
        end
    end

endmodule

`default_nettype wire

// ==== usb_dump_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module usb_dump_properties (
    input wire        MCLK,
    input wire        rst_n,
    input wire        txe_n,
    input wire  [7:0] fifo_data,
    input wire        fifo_wr_n
);

    int unsigned fail_count = 0;   // assertion failures so far

    // write strobe is low for exactly two clocks
    assert property (@(posedge MCLK) disable iff (!rst_n)
        $fell(fifo_wr_n) |-> ##1 !fifo_wr_n ##1 fifo_wr_n)
        else begin
            fail_count++;
            $error("fifo_wr_n low pulse is not two cycles long");
        end

    assert property (@(posedge MCLK) disable iff (!rst_n)
        !fifo_wr_n |-> $stable(fifo_data))
        else begin
            fail_count++;
            $error("fifo_data changed while fifo_wr_n was low");
        end

    // room is sampled one edge before the strobe is driven low
    assert property (@(posedge MCLK) disable iff (!rst_n)
        $fell(fifo_wr_n) |-> !$past(txe_n, 2))
        else begin
            fail_count++;
            $error("fifo_wr_n fell without txe_n low beforehand");
        end

endmodule

bind fifo_byte_writer usb_dump_properties usb_dump_properties_i (
    .MCLK      (MCLK),
    .rst_n     (rst_n),
    .txe_n     (txe_n),
    .fifo_data (fifo_data),
    .fifo_wr_n (fifo_wr_n)
);

`default_nettype wire

// ==== usb_dump_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module usb_dump_tb
    import usb_fifo_pkg::*;
    import dump_format_pkg::*;
();

    localparam logic [31:0] SEED = 32'd54648;
    localparam int STREAM_MAX_CHARS = BOOT_TITLE_LEN + BOOT_LINES * (3 * BYTES_PER_LINE + 2) + 2;
    localparam int TIMEOUT_CYCLES = 5 * STREAM_MAX_CHARS * 40 + BUF_BITS;   // 5 streams, 1 fill
    localparam int QUIET_CYCLES = 40;

    logic                      MCLK;
    logic                      rst_n;
    logic                      buf_wr_en_n;
    logic [BUF_WR_ADDR_W-1:0]  buf_wr_addr;
    logic                      buf_wr_data;
    logic                      send_boot_n;
    logic                      send_user_n;
    logic [PAGE_W-1:0]         rel_page;
    logic                      fifo_en_n;
    logic                      txe_n = 1'b1;
    fifo_byte_t                fifo_data;
    logic                      fifo_wr_n;

    fifo_byte_t   model_mem [0:BUF_BITS/8-1];   // reference copy of the buffer
    fifo_byte_t   expected [$];
    fifo_byte_t   captured [$];
    logic [31:0]  rng_data = SEED;
    logic [31:0]  rng_txe = SEED;
    int unsigned  busy_pct = 30;   // percent of cycles with txe_n high
    int           cycle_cnt = 0;
    int           err_count = 0;

    tb_clock_gen tb_clock_gen_i (
        .MCLK  (MCLK),
        .rst_n (rst_n)
    );

    usb_dump_top usb_dump_top_i (
        .MCLK        (MCLK),
        .rst_n       (rst_n),
        .buf_wr_en_n (buf_wr_en_n),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .send_boot_n (send_boot_n),
        .send_user_n (send_user_n),
        .rel_page    (rel_page),
        .fifo_en_n   (fifo_en_n),
        .txe_n       (txe_n),
        .fifo_data   (fifo_data),
        .fifo_wr_n   (fifo_wr_n)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic fifo_byte_t hex_char(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'h30 + {4'h0, n};   // '0'..'9'
        end
        return 8'h41 + {4'h0, n} - 8'd10;   // 'A'..'F'
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] exp_val,
                               input string what);
        if (actual !== exp_val) begin
            $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, exp_val);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic draw_random(output logic [31:0] r);
        rng_data = xorshift32(rng_data);
        r = rng_data;
    endtask

    task automatic fill_buffer();
        logic [31:0] r;
        logic [12:0] a;
        for (int i = 0; i < BUF_BITS; i++) begin
            draw_random(r);
            a = 13'(i);
            @(posedge MCLK);
            buf_wr_en_n <= 1'b0;
            buf_wr_addr <= a;
            buf_wr_data <= r[7];
            model_mem[a[12:3]][a[2:0]] = r[7];   // lsb first within a byte
        end
        @(posedge MCLK);
        buf_wr_en_n <= 1'b1;
    endtask

    // flips the bit at each random address so the new dump must differ
    task automatic rewrite_bits(input int count);
        logic [31:0] r;
        logic [12:0] a;
        logic        flip;
        for (int k = 0; k < count; k++) begin
            draw_random(r);
            a = r[12:0];
            flip = ~model_mem[a[12:3]][a[2:0]];
            @(posedge MCLK);
            buf_wr_en_n <= 1'b0;
            buf_wr_addr <= a;
            buf_wr_data <= flip;
            model_mem[a[12:3]][a[2:0]] = flip;
        end
        @(posedge MCLK);
        buf_wr_en_n <= 1'b1;
    endtask

    task automatic build_expected(input logic boot, input logic [PAGE_W-1:0] page);
        int         lines;
        int         addr;
        fifo_byte_t b;
        expected.delete();
        if (boot) begin
            for (int i = 0; i < BOOT_TITLE_LEN; i++) begin
                expected.push_back(BOOT_TITLE[8*(BOOT_TITLE_LEN-1-i) +: 8]);
            end
            lines = BOOT_LINES;
        end else begin
            for (int i = 0; i < USER_TITLE_LEN; i++) begin
                expected.push_back(USER_TITLE[8*(USER_TITLE_LEN-1-i) +: 8]);
            end
            for (int d = PAGE_DIGITS - 1; d >= 0; d--) begin
                expected.push_back(hex_char(page[4*d +: 4]));   // msb digit first
            end
            expected.push_back(CHAR_CR);
            expected.push_back(CHAR_LF);
            lines = USER_LINES;
        end
        addr = 0;
        for (int l = 0; l < lines; l++) begin
            for (int k = 0; k < BYTES_PER_LINE; k++) begin
                b = model_mem[addr];
                expected.push_back(hex_char(b[7:4]));
                expected.push_back(hex_char(b[3:0]));
                expected.push_back(CHAR_SPACE);
                addr++;
            end
            expected.push_back(CHAR_CR);
            expected.push_back(CHAR_LF);
        end
        expected.push_back(CHAR_CR);   // closing line of the stream
        expected.push_back(CHAR_LF);
    endtask

    task automatic request_stream(input logic boot_n, input logic user_n,
                                  input logic [PAGE_W-1:0] page);
        @(posedge MCLK);
        send_boot_n <= boot_n;
        send_user_n <= user_n;
        rel_page    <= page;
    endtask

    task automatic collect_stream(input string name);
        while (captured.size() < expected.size()) @(posedge MCLK);
        while (!fifo_wr_n) @(posedge MCLK);   // last strobe still running
        @(posedge MCLK);
        send_boot_n <= 1'b1;
        send_user_n <= 1'b1;
        repeat (QUIET_CYCLES) @(posedge MCLK);   // nothing may follow the final CR LF
        check_value(32'(captured.size()), 32'(expected.size()),
                    $sformatf("%s character count", name));
        for (int i = 0; i < expected.size(); i++) begin
            check_value(32'(captured[i]), 32'(expected[i]),
                        $sformatf("%s character %0d", name, i));
        end
        captured.delete();
    endtask

    // one FIFO write per falling strobe
    always @(negedge fifo_wr_n) begin
        captured.push_back(fifo_data);
    end

    always @(posedge MCLK) begin
        rng_txe = xorshift32(rng_txe);
        txe_n <= ((rng_txe % 32'd100) < busy_pct);
    end

    always @(posedge MCLK) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, the test did not finish within %0d cycles", cycle_cnt);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0]       r;
        logic [PAGE_W-1:0] page;
        buf_wr_en_n = 1'b1;
        buf_wr_addr = '0;
        buf_wr_data = 1'b0;
        send_boot_n = 1'b1;
        send_user_n = 1'b1;
        rel_page    = '0;
        fifo_en_n   = 1'b1;

        @(posedge rst_n);
        @(negedge MCLK);
        check_value(32'(fifo_wr_n), 32'd1, "fifo_wr_n after reset");
        check_value(32'(fifo_data), 32'(CHAR_SPACE), "fifo_data after reset");

        fill_buffer();
        request_stream(1'b0, 1'b1, '0);
        repeat (200) @(posedge MCLK);   // FIFO mode still off
        check_value(32'(captured.size()), 32'd0, "writes while fifo_en_n is high");
        fifo_en_n <= 1'b0;
        build_expected(1'b1, '0);
        collect_stream("boot dump");

        draw_random(r);
        page = r[PAGE_W-1:0];
        build_expected(1'b0, page);
        request_stream(1'b1, 1'b0, page);
        collect_stream("user dump");

        busy_pct <= 60;
        build_expected(1'b1, '0);
        request_stream(1'b0, 1'b1, '0);
        collect_stream("boot dump under back-pressure");

        busy_pct <= 40;
        rewrite_bits(64);
        draw_random(r);
        page = r[PAGE_W-1:0];
        build_expected(1'b1, page);
        request_stream(1'b0, 1'b0, page);   // boot has priority
        collect_stream("boot dump with both requests");

        draw_random(r);
        page = r[PAGE_W-1:0];
        build_expected(1'b0, page);
        request_stream(1'b1, 1'b0, page);
        collect_stream("user dump after release");

        // failures of the bound write-cycle assertions
        err_count = usb_dump_top_i.fifo_byte_writer_i.usb_dump_properties_i.fail_count;
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("ERROR: %0d assertion failures on the FIFO write cycle", err_count);
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== usb_dump_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module usb_dump_top
    import usb_fifo_pkg::*;
    import dump_format_pkg::*;
(
    input  wire                      MCLK,
    input  wire                      rst_n,

    input  wire                      buf_wr_en_n,
    input  wire [BUF_WR_ADDR_W-1:0]  buf_wr_addr,
    input  wire                      buf_wr_data,

    input  wire                      send_boot_n,
    input  wire                      send_user_n,
    input  wire [PAGE_W-1:0]         rel_page,

    input  wire                      fifo_en_n,
    input  wire                      txe_n,
    output fifo_byte_t               fifo_data,
    output logic                     fifo_wr_n
);

    logic                      buf_rd_en;
    logic [BUF_RD_ADDR_W-1:0]  buf_rd_addr;
    fifo_byte_t                buf_rd_data;
    logic                      rom_rd_en;
    logic [ROM_ADDR_W-1:0]     rom_addr;
    fifo_byte_t                rom_data;
    logic                      char_send;
    fifo_byte_t                char_byte;
    logic                      char_done;

    bit_buffer bit_buffer_i (
        .MCLK    (MCLK),
        .rst_n   (rst_n),
        .wr_en_n (buf_wr_en_n),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .rd_en   (buf_rd_en),
        .rd_addr (buf_rd_addr),
        .rd_data (buf_rd_data)
    );

    text_rom text_rom_i (
        .MCLK  (MCLK),
        .rst_n (rst_n),
        .rd_en (rom_rd_en),
        .addr  (rom_addr),
        .data  (rom_data)
    );

    dump_sequencer dump_sequencer_i (
        .MCLK        (MCLK),
        .rst_n       (rst_n),
        .fifo_en_n   (fifo_en_n),
        .send_boot_n (send_boot_n),
        .send_user_n (send_user_n),
        .rel_page    (rel_page),
        .buf_rd_en   (buf_rd_en),
        .buf_rd_addr (buf_rd_addr),
        .buf_rd_data (buf_rd_data),
        .rom_rd_en   (rom_rd_en),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .char_send   (char_send),
        .char_byte   (char_byte),
        .char_done   (char_done)
    );

    fifo_byte_writer fifo_byte_writer_i (
        .MCLK      (MCLK),
        .rst_n     (rst_n),
        .char_send (char_send),
        .char_byte (char_byte),
        .txe_n     (txe_n),
        .char_done (char_done),
        .fifo_data (fifo_data),
        .fifo_wr_n (fifo_wr_n)
    );

endmodule

`default_nettype wire

// ==== usb_fifo_pkg.sv ====
`default_nettype none

package usb_fifo_pkg;

    // one byte on the FT245 data bus
    typedef logic [7:0] fifo_byte_t;

    localparam fifo_byte_t CHAR_CR    = 8'h0D;   // carriage return
    localparam fifo_byte_t CHAR_LF    = 8'h0A;   // line feed
    localparam fifo_byte_t CHAR_SPACE = 8'h20;   // idle value of the bus latch

endpackage

`default_nettype wire
